/* src/tg_cfg_pkg.sv */
// Traffic generator cluster configuration
// Cluster size, ID pool, read region and statistics widths
// Run configuration and per-core statistics structs

package tg_cfg_pkg;

  localparam int unsigned NumCores = 4;
  localparam int unsigned IdWidth = 3;
  localparam int unsigned NumIds = 2 ** IdWidth;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  // Read region, aligned to its own size
  localparam logic [AddrWidth-1:0] RegionBase = 16'h4000;
  localparam int unsigned RegionWords = 1024;
  localparam int unsigned RegionOffWidth = $clog2(RegionWords);

  localparam int unsigned ProbWidth = 10;
  localparam int unsigned CycleWidth = 16;
  localparam int unsigned SeedWidth = 16;

  localparam int unsigned CountWidth = 16;
  localparam int unsigned LatSumWidth = 24;
  localparam int unsigned LatMaxWidth = 8;

  typedef struct packed {
    logic [NumCores-1:0]   core_mask;
    logic [ProbWidth-1:0]  prob;
    logic [CycleWidth-1:0] num_cycles;
    logic [SeedWidth-1:0]  seed;
  } tg_run_cfg_t;

  typedef struct packed {
    logic [CountWidth-1:0]  issued;
    logic [CountWidth-1:0]  completed;
    logic [LatSumWidth-1:0] lat_sum;
    logic [LatMaxWidth-1:0] lat_max;
  } tg_stats_t;

endpackage

/* src/tcdm_pkg.sv */
// Scratchpad interconnect definitions
// Bank count, bank index and row widths
// Read request and tagged response structs

package tcdm_pkg;

  localparam int unsigned NumBanks = 4;
  localparam int unsigned BankSelWidth = $clog2(NumBanks);
  localparam int unsigned BankWords = tg_cfg_pkg::RegionWords / NumBanks;
  localparam int unsigned BankRowWidth = $clog2(BankWords);

  // Word address, byte offset dropped
  localparam int unsigned WordAddrWidth = tg_cfg_pkg::AddrWidth - 2;
  localparam int unsigned CoreIdxWidth = $clog2(tg_cfg_pkg::NumCores);

  typedef struct packed {
    logic [WordAddrWidth-1:0]       addr;
    logic [tg_cfg_pkg::IdWidth-1:0] id;
    logic [CoreIdxWidth-1:0]        core;
  } tcdm_req_t;

  typedef struct packed {
    logic [tg_cfg_pkg::DataWidth-1:0] data;
    logic [tg_cfg_pkg::IdWidth-1:0]   id;
    logic [CoreIdxWidth-1:0]          core;
  } tcdm_resp_t;

endpackage

/* src/rr_arbiter.sv */
// Round-robin arbiter, N valid/ready inputs to one output
// Combinational grant, payload type given as a parameter

module rr_arbiter #(
  parameter int unsigned NumIn = 4,
  parameter type payload_t = logic
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic     [NumIn-1:0] valid_i,
  input  payload_t [NumIn-1:0] payload_i,
  output logic     [NumIn-1:0] ready_o,
  output logic                 valid_o,
  output payload_t             payload_o,
  input  logic                 ready_i
);

  localparam int unsigned SelWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [SelWidth-1:0] ptr_q;
  logic [SelWidth-1:0] grant;
  logic                found;

  // Scan from the priority pointer and wrap around
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    grant = ptr_q;
    for (int unsigned i = 0; i < NumIn; i++) begin
      idx = (32'(ptr_q) + i) % NumIn;
      if (!found && valid_i[idx]) begin
        found = 1'b1;
        grant = SelWidth'(idx);
      end
    end
  end

  assign valid_o = found;
  assign payload_o = payload_i[grant];

  always_comb begin
    ready_o = '0;
    ready_o[grant] = found & ready_i;
  end

  // Winner gets lowest priority next time
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found && ready_i) begin
      ptr_q <= (grant == SelWidth'(NumIn - 1)) ? '0 : grant + 1'b1;
    end
  end

endmodule

/* src/tcdm_bank.sv */
// Scratchpad bank with one-cycle read latency
// Response is held until taken, new requests stall meanwhile

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  input  tcdm_pkg::tcdm_req_t  req_i,
  output logic                 req_ready_o,
  output logic                 resp_valid_o,
  output tcdm_pkg::tcdm_resp_t resp_o,
  input  logic                 resp_ready_i
);

  logic [tg_cfg_pkg::DataWidth-1:0] mem_q [tcdm_pkg::BankWords];
  logic [tcdm_pkg::BankRowWidth-1:0] row;
  logic                              resp_valid_q;
  tcdm_pkg::tcdm_resp_t              resp_q;

  initial begin
    for (int i = 0; i < tcdm_pkg::BankWords; i++) begin
      mem_q[i] = '0;
    end
  end

  // Low word bits picked the bank, next bits pick the row
  assign row = req_i.addr[tcdm_pkg::BankSelWidth +: tcdm_pkg::BankRowWidth];
  assign req_ready_o = !resp_valid_q || resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      resp_q.data <= mem_q[row];
      resp_q.id <= req_i.id;
      resp_q.core <= req_i.core;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o = resp_q;

endmodule

/* src/tcdm_xbar.sv */
// Core-to-bank request crossbar and bank-to-core response crossbar
// One round-robin arbiter per bank and one per core

module tcdm_xbar (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic                 [tg_cfg_pkg::NumCores-1:0]   core_req_valid_i,
  input  tcdm_pkg::tcdm_req_t  [tg_cfg_pkg::NumCores-1:0]   core_req_i,
  output logic                 [tg_cfg_pkg::NumCores-1:0]   core_req_ready_o,
  output logic                 [tg_cfg_pkg::NumCores-1:0]   core_resp_valid_o,
  output tcdm_pkg::tcdm_resp_t [tg_cfg_pkg::NumCores-1:0]   core_resp_o,
  output logic                 [tcdm_pkg::NumBanks-1:0]     bank_req_valid_o,
  output tcdm_pkg::tcdm_req_t  [tcdm_pkg::NumBanks-1:0]     bank_req_o,
  input  logic                 [tcdm_pkg::NumBanks-1:0]     bank_req_ready_i,
  input  logic                 [tcdm_pkg::NumBanks-1:0]     bank_resp_valid_i,
  input  tcdm_pkg::tcdm_resp_t [tcdm_pkg::NumBanks-1:0]     bank_resp_i,
  output logic                 [tcdm_pkg::NumBanks-1:0]     bank_resp_ready_o
);

  localparam int unsigned NumCores = tg_cfg_pkg::NumCores;
  localparam int unsigned NumBanks = tcdm_pkg::NumBanks;
  localparam int unsigned SelWidth = tcdm_pkg::BankSelWidth;
  localparam int unsigned CoreWidth = tcdm_pkg::CoreIdxWidth;

  logic [NumBanks-1:0][NumCores-1:0] bank_valid;
  logic [NumBanks-1:0][NumCores-1:0] bank_ready;
  logic [NumCores-1:0][NumBanks-1:0] core_valid;
  logic [NumCores-1:0][NumBanks-1:0] core_ready;

  // Steer requests by bank bits and responses by core index
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int c = 0; c < NumCores; c++) begin
        bank_valid[b][c] = core_req_valid_i[c] &&
                           (core_req_i[c].addr[SelWidth-1:0] == SelWidth'(b));
        core_valid[c][b] = bank_resp_valid_i[b] && (bank_resp_i[b].core == CoreWidth'(c));
      end
    end
  end

  // Only the addressed arbiter can grant, so OR the readies
  always_comb begin
    core_req_ready_o = '0;
    bank_resp_ready_o = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int c = 0; c < NumCores; c++) begin
        core_req_ready_o[c] = core_req_ready_o[c] | bank_ready[b][c];
        bank_resp_ready_o[b] = bank_resp_ready_o[b] | core_ready[c][b];
      end
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_arb
    rr_arbiter #(
      .NumIn    (NumCores),
      .payload_t(tcdm_pkg::tcdm_req_t)
    ) i_req_arb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .valid_i  (bank_valid[b]),
      .payload_i(core_req_i),
      .ready_o  (bank_ready[b]),
      .valid_o  (bank_req_valid_o[b]),
      .payload_o(bank_req_o[b]),
      .ready_i  (bank_req_ready_i[b])
    );
  end

  // Generators always take their responses
  for (genvar c = 0; c < NumCores; c++) begin : gen_core_arb
    rr_arbiter #(
      .NumIn    (NumBanks),
      .payload_t(tcdm_pkg::tcdm_resp_t)
    ) i_resp_arb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .valid_i  (core_valid[c]),
      .payload_i(bank_resp_i),
      .ready_o  (core_ready[c]),
      .valid_o  (core_resp_valid_o[c]),
      .payload_o(core_resp_o[c]),
      .ready_i  (1'b1)
    );
  end

endmodule

/* src/traffic_gen.sv */
// Random read generator for one core
// LFSR request decision and address, ID pool with lowest-free search,
// per-ID timestamps and saturating latency statistics

module traffic_gen #(
  parameter int unsigned CoreIdx = 0
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    active_i,
  input  logic                    clear_i,
  input  tg_cfg_pkg::tg_run_cfg_t cfg_i,
  output logic                    req_valid_o,
  output tcdm_pkg::tcdm_req_t     req_o,
  input  logic                    req_ready_i,
  input  logic                    resp_valid_i,
  input  tcdm_pkg::tcdm_resp_t    resp_i,
  output logic                    idle_o,
  output tg_cfg_pkg::tg_stats_t   stats_o
);

  localparam int unsigned NumIds = tg_cfg_pkg::NumIds;
  localparam int unsigned IdWidth = tg_cfg_pkg::IdWidth;
  localparam int unsigned CycleWidth = tg_cfg_pkg::CycleWidth;
  localparam int unsigned SeedWidth = tg_cfg_pkg::SeedWidth;
  localparam int unsigned SumWidth = tg_cfg_pkg::LatSumWidth;
  localparam int unsigned MaxWidth = tg_cfg_pkg::LatMaxWidth;
  localparam int unsigned WordWidth = tcdm_pkg::WordAddrWidth;
  localparam logic [WordWidth-1:0] RegionWordBase = WordWidth'(tg_cfg_pkg::RegionBase >> 2);
  // x^16 + x^14 + x^13 + x^11, Galois form
  localparam logic [SeedWidth-1:0] LfsrTaps = 16'hB400;

  logic [SeedWidth-1:0]  lfsr_q;
  logic [SeedWidth-1:0]  seed_val;
  logic [CycleWidth-1:0] now_q;
  logic [NumIds-1:0]     pending_q;
  logic [NumIds-1:0]     pending_d;
  logic [NumIds-1:0]     busy;
  logic [IdWidth-1:0]    free_id;
  logic                  decide;
  logic                  accept;
  logic                  req_valid_q;
  tcdm_pkg::tcdm_req_t   req_q;
  logic [CycleWidth-1:0] stamp_q [NumIds];
  logic [CycleWidth-1:0] latency;
  logic [MaxWidth-1:0]   lat_clip;
  logic [SumWidth:0]     lat_sum_ext;
  tg_cfg_pkg::tg_stats_t stats_q;

  // A zero seed would lock the LFSR
  assign seed_val = cfg_i.seed ^ SeedWidth'(CoreIdx);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q <= SeedWidth'(1);
    end else if (clear_i) begin
      lfsr_q <= (seed_val == '0) ? SeedWidth'(1) : seed_val;
    end else begin
      lfsr_q <= {1'b0, lfsr_q[SeedWidth-1:1]} ^ ({SeedWidth{lfsr_q[0]}} & LfsrTaps);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      now_q <= '0;
    end else begin
      now_q <= now_q + 1'b1;
    end
  end

  // Held request owns its ID too, lowest free one wins
  always_comb begin
    busy = pending_q;
    if (req_valid_q) begin
      busy[req_q.id] = 1'b1;
    end
    free_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_id = IdWidth'(i);
      end
    end
  end

  // No decision in the clear cycle, so a seed replays exactly
  assign decide = active_i && !clear_i && !(&busy) && (!req_valid_q || req_ready_i) &&
                  (lfsr_q[tg_cfg_pkg::ProbWidth-1:0] < cfg_i.prob);
  assign accept = req_valid_q && req_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
    end else if (decide) begin
      req_valid_q <= 1'b1;
    end else if (accept) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (decide) begin
      req_q.addr <= RegionWordBase |
                    WordWidth'(lfsr_q[SeedWidth-1 -: tg_cfg_pkg::RegionOffWidth]);
      req_q.id <= free_id;
      req_q.core <= tcdm_pkg::CoreIdxWidth'(CoreIdx);
    end
  end

  always_comb begin
    pending_d = pending_q;
    if (accept) begin
      pending_d[req_q.id] = 1'b1;
    end
    if (resp_valid_i) begin
      pending_d[resp_i.id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stamp_q[req_q.id] <= now_q;
    end
  end

  // Latency from accepting edge to response edge
  assign latency = now_q - stamp_q[resp_i.id];
  assign lat_clip = (|latency[CycleWidth-1:MaxWidth]) ? '1 : latency[MaxWidth-1:0];
  assign lat_sum_ext = {1'b0, stats_q.lat_sum} + (SumWidth + 1)'(latency);

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      stats_q <= '0;
    end else begin
      if (accept && !(&stats_q.issued)) begin
        stats_q.issued <= stats_q.issued + 1'b1;
      end
      if (resp_valid_i) begin
        if (!(&stats_q.completed)) begin
          stats_q.completed <= stats_q.completed + 1'b1;
        end
        stats_q.lat_sum <= lat_sum_ext[SumWidth] ? '1 : lat_sum_ext[SumWidth-1:0];
        if (lat_clip > stats_q.lat_max) begin
          stats_q.lat_max <= lat_clip;
        end
      end
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o = req_q;
  assign idle_o = !req_valid_q && (pending_q == '0);
  assign stats_o = stats_q;

endmodule

/* src/tg_control.sv */
// Run controller for the traffic generators
// Latches the run configuration, times the active window,
// then waits for every generator to drain

module tg_control (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  start_i,
  input  tg_cfg_pkg::tg_run_cfg_t               cfg_i,
  input  logic [tg_cfg_pkg::NumCores-1:0]       idle_i,
  output logic [tg_cfg_pkg::NumCores-1:0]       active_o,
  output logic                                  clear_o,
  output tg_cfg_pkg::tg_run_cfg_t               cfg_o,
  output logic                                  done_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRun,
    StDrain,
    StDone
  } state_e;

  state_e                            state_q;
  logic [tg_cfg_pkg::CycleWidth-1:0] count_q;
  logic                              clear_q;
  logic                              start;
  tg_cfg_pkg::tg_run_cfg_t           cfg_q;

  // Starts only between runs
  assign start = start_i && (state_q == StIdle || state_q == StDone);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StIdle;
      count_q <= '0;
      clear_q <= 1'b0;
    end else begin
      clear_q <= start;
      case (state_q)
        StIdle, StDone: begin
          if (start) begin
            count_q <= cfg_i.num_cycles;
            state_q <= (cfg_i.num_cycles == '0) ? StDrain : StRun;
          end
        end
        StRun: begin
          count_q <= count_q - 1'b1;
          if (count_q == 1) begin
            state_q <= StDrain;
          end
        end
        StDrain: begin
          if (&idle_i) begin
            state_q <= StDone;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      cfg_q <= cfg_i;
    end
  end

  assign active_o = (state_q == StRun) ? cfg_q.core_mask : '0;
  assign clear_o = clear_q;
  assign cfg_o = cfg_q;
  assign done_o = (state_q == StDone);

endmodule

/* src/tg_cluster.sv */
// Traffic generator cluster top level
// Run controller, generator loop, crossbar and scratchpad banks

module tg_cluster (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic                                              start_i,
  input  tg_cfg_pkg::tg_run_cfg_t                           cfg_i,
  output logic                                              done_o,
  output tg_cfg_pkg::tg_stats_t [tg_cfg_pkg::NumCores-1:0]  stats_o
);

  localparam int unsigned NumCores = tg_cfg_pkg::NumCores;
  localparam int unsigned NumBanks = tcdm_pkg::NumBanks;

  logic [NumCores-1:0]                  active;
  logic [NumCores-1:0]                  idle;
  logic                                 clear;
  logic                                 xbar_reset;
  tg_cfg_pkg::tg_run_cfg_t              run_cfg;
  logic [NumCores-1:0]                  core_req_valid;
  logic [NumCores-1:0]                  core_req_ready;
  tcdm_pkg::tcdm_req_t  [NumCores-1:0]  core_req;
  logic [NumCores-1:0]                  core_resp_valid;
  tcdm_pkg::tcdm_resp_t [NumCores-1:0]  core_resp;
  logic [NumBanks-1:0]                  bank_req_valid;
  logic [NumBanks-1:0]                  bank_req_ready;
  tcdm_pkg::tcdm_req_t  [NumBanks-1:0]  bank_req;
  logic [NumBanks-1:0]                  bank_resp_valid;
  logic [NumBanks-1:0]                  bank_resp_ready;
  tcdm_pkg::tcdm_resp_t [NumBanks-1:0]  bank_resp;

  tg_control i_tg_control (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_i),
    .cfg_i   (cfg_i),
    .idle_i  (idle),
    .active_o(active),
    .clear_o (clear),
    .cfg_o   (run_cfg),
    .done_o  (done_o)
  );

  for (genvar c = 0; c < NumCores; c++) begin : gen_core
    traffic_gen #(
      .CoreIdx(c)
    ) i_traffic_gen (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .active_i    (active[c]),
      .clear_i     (clear),
      .cfg_i       (run_cfg),
      .req_valid_o (core_req_valid[c]),
      .req_o       (core_req[c]),
      .req_ready_i (core_req_ready[c]),
      .resp_valid_i(core_resp_valid[c]),
      .resp_i      (core_resp[c]),
      .idle_o      (idle[c]),
      .stats_o     (stats_o[c])
    );
  end

  // Arbiter pointers restart with each run so a repeated seed replays exactly
  assign xbar_reset = reset_i | clear;

  tcdm_xbar i_tcdm_xbar (
    .clk_i            (clk_i),
    .reset_i          (xbar_reset),
    .core_req_valid_i (core_req_valid),
    .core_req_i       (core_req),
    .core_req_ready_o (core_req_ready),
    .core_resp_valid_o(core_resp_valid),
    .core_resp_o      (core_resp),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_o       (bank_req),
    .bank_req_ready_i (bank_req_ready),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_i      (bank_resp),
    .bank_resp_ready_o(bank_resp_ready)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank i_tcdm_bank (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_valid_i (bank_req_valid[b]),
      .req_i       (bank_req[b]),
      .req_ready_o (bank_req_ready[b]),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_o      (bank_resp[b]),
      .resp_ready_i(bank_resp_ready[b])
    );
  end

endmodule

/* test/tb_tg_cluster.sv */
// Testbench for the traffic generator cluster
// Reads run configurations from a pattern file, runs each one
// and checks the per-core statistics against the run rules

module tb_tg_cluster;
  timeunit 1ns;
  timeprecision 10ps;

  localparam int unsigned NumCores = tg_cfg_pkg::NumCores;
  localparam int TimeoutCycles = 5000;

  typedef tg_cfg_pkg::tg_stats_t [NumCores-1:0] stats_vec_t;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    start;
  tg_cfg_pkg::tg_run_cfg_t run_cfg;
  logic                    done;
  stats_vec_t              stats;

  int error_count = 0;
  int check_count = 0;
  int timeout_count = 0;
  int run_count = 0;

  // Earlier runs, kept for the repeat class
  tg_cfg_pkg::tg_run_cfg_t cfg_hist[$];
  stats_vec_t              stats_hist[$];

  tg_cluster i_tg_cluster (
    .clk_i  (clk),
    .reset_i(reset),
    .start_i(start),
    .cfg_i  (run_cfg),
    .done_o (done),
    .stats_o(stats)
  );

  always #4 clk = ~clk;

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_done(input logic exp, input string what);
    check_count++;
    if (done !== exp) begin
      error_count++;
      $display("[ERROR] %0d ns: done_o is %b %s, expected %b", $time, done, what, exp);
    end
  endtask

  task automatic check_stats(input int core, input tg_cfg_pkg::tg_stats_t got,
                             input tg_cfg_pkg::tg_stats_t lo,
                             input tg_cfg_pkg::tg_stats_t hi);
    check_count++;
    if (got.issued < lo.issued || got.issued > hi.issued) begin
      error_count++;
      $display("[ERROR] %0d ns: core %0d issued %0d, expected %0d..%0d",
               $time, core, got.issued, lo.issued, hi.issued);
    end
    if (got.completed < lo.completed || got.completed > hi.completed) begin
      error_count++;
      $display("[ERROR] %0d ns: core %0d completed %0d, expected %0d..%0d",
               $time, core, got.completed, lo.completed, hi.completed);
    end
    if (got.lat_sum < lo.lat_sum || got.lat_sum > hi.lat_sum) begin
      error_count++;
      $display("[ERROR] %0d ns: core %0d latency sum %0d, expected %0d..%0d",
               $time, core, got.lat_sum, lo.lat_sum, hi.lat_sum);
    end
    if (got.lat_max < lo.lat_max || got.lat_max > hi.lat_max) begin
      error_count++;
      $display("[ERROR] %0d ns: core %0d latency max %0d, expected %0d..%0d",
               $time, core, got.lat_max, lo.lat_max, hi.lat_max);
    end
  endtask

  task automatic wait_done(output bit ok);
    int cycles;
    cycles = 0;
    while (done !== 1'b1 && cycles < TimeoutCycles) begin
      step();
      cycles++;
    end
    ok = (done === 1'b1);
    if (!ok) begin
      timeout_count++;
      $display("Timeout: done_o did not rise within %0d cycles of the start", TimeoutCycles);
    end
  endtask

  // Bounds per core follow the class of the pattern line
  task automatic apply_rules(input tg_cfg_pkg::tg_run_cfg_t cfg, input int cls);
    stats_vec_t            got;
    stats_vec_t            ref_stats;
    tg_cfg_pkg::tg_stats_t lo;
    tg_cfg_pkg::tg_stats_t hi;
    int                    prod;
    bit                    found;
    got = stats;
    found = 1'b0;
    ref_stats = '0;
    if (cls == 3) begin
      for (int i = cfg_hist.size() - 1; i >= 0 && !found; i--) begin
        if (cfg_hist[i] == cfg) begin
          found = 1'b1;
          ref_stats = stats_hist[i];
        end
      end
      if (!found) begin
        error_count++;
        $display("Repeat line at run %0d has no earlier run with the same settings", run_count);
      end
    end else if (cls < 0 || cls > 3) begin
      error_count++;
      $display("Pattern line at run %0d has an unknown check class %0d", run_count, cls);
    end
    for (int c = 0; c < NumCores; c++) begin
      lo = '0;
      hi = '0;
      if (cls == 3) begin
        lo = ref_stats[c];
        hi = ref_stats[c];
      end else if (cfg.core_mask[c] && (cls == 1 || cls == 2)) begin
        lo.issued = 1;
        hi.issued = cfg.num_cycles;
        lo.completed = got[c].issued;
        hi.completed = got[c].issued;
        if (cls == 1) begin
          // Uncontended reads always take one cycle
          lo.lat_sum = got[c].completed;
          hi.lat_sum = got[c].completed;
          lo.lat_max = 1;
          hi.lat_max = 1;
        end else begin
          prod = int'(got[c].completed) * int'(got[c].lat_max);
          lo.lat_sum = got[c].completed;
          hi.lat_sum = prod[tg_cfg_pkg::LatSumWidth-1:0];
          lo.lat_max = 1;
          hi.lat_max = '1;
        end
      end
      check_stats(c, got[c], lo, hi);
    end
    cfg_hist.push_back(cfg);
    stats_hist.push_back(got);
  endtask

  task automatic run_pattern(input tg_cfg_pkg::tg_run_cfg_t cfg, input int cls,
                             output bit ok);
    run_cfg = cfg;
    start = 1'b1;
    step();
    start = 1'b0;
    run_cfg = '0;
    check_done(1'b0, "right after start");
    wait_done(ok);
    if (ok) begin
      step();
      check_done(1'b1, "one cycle after the run ended");
      apply_rules(cfg, cls);
    end
  endtask

  int                      fd;
  int                      code;
  int                      fields;
  int                      cls;
  string                   line;
  logic [31:0]             mask_v;
  logic [31:0]             prob_v;
  logic [31:0]             cycles_v;
  logic [31:0]             seed_v;
  tg_cfg_pkg::tg_run_cfg_t cfg;
  bit                      ok;

  initial begin
    reset = 1'b1;
    start = 1'b0;
    run_cfg = '0;
    ok = 1'b1;
    repeat (8) step();
    reset = 1'b0;
    step();

    check_done(1'b0, "after reset");
    for (int c = 0; c < NumCores; c++) begin
      check_stats(c, stats[c], '0, '0);
    end

    fd = $fopen("test/tg_patterns.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the pattern file test/tg_patterns.txt");
    end else begin
      while (ok) begin
        code = $fgets(line, fd);
        if (code == 0) begin
          break;
        end
        // Comment and blank lines do not parse into five fields
        fields = $sscanf(line, "%h %d %d %h %d", mask_v, prob_v, cycles_v, seed_v, cls);
        if (fields != 5) begin
          continue;
        end
        cfg.core_mask = mask_v[NumCores-1:0];
        cfg.prob = prob_v[tg_cfg_pkg::ProbWidth-1:0];
        cfg.num_cycles = cycles_v[tg_cfg_pkg::CycleWidth-1:0];
        cfg.seed = seed_v[tg_cfg_pkg::SeedWidth-1:0];
        run_count++;
        run_pattern(cfg, cls, ok);
      end
      $fclose(fd);
      if (run_count == 0) begin
        error_count++;
        $display("The pattern file holds no run configuration");
      end
    end

    $display("Runs: %0d, checks: %0d, errors: %0d, timeouts: %0d",
             run_count, check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* files.f */
src/tg_cfg_pkg.sv
src/tcdm_pkg.sv
src/rr_arbiter.sv
src/tcdm_bank.sv
src/tcdm_xbar.sv
src/traffic_gen.sv
src/tg_control.sv
src/tg_cluster.sv
test/tb_tg_cluster.sv

/* Makefile */
# Verilator build of the traffic generator cluster testbench

SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv)

obj_dir/Vtb_tg_cluster: files.f $(SOURCES)
	verilator --binary --timing -Wno-fatal -f files.f --top-module tb_tg_cluster \
		-o Vtb_tg_cluster

run: obj_dir/Vtb_tg_cluster
	./obj_dir/Vtb_tg_cluster | tee sim.log

check: run
	grep -q "Testbench passed" sim.log

all: check

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean

/* test/tg_patterns.txt */
# mask(hex) probability run_cycles seed(hex) class
# class: 0 all zero, 1 single core, 2 bounds per core, 3 repeat of an earlier run
f 0 200 1234 0
0 1023 100 1111 0
1 1023 300 ace1 1
4 1023 150 0001 1
8 1023 64 7f3c 1
f 1023 400 beef 2
3 1023 200 1357 2
f 700 300 5a5a 2
f 1023 50 0000 2
f 1023 400 beef 3
1 1023 300 ace1 3
f 700 300 5a5a 3
a 512 250 c0de 2
a 512 250 c0de 3
